// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operands, results and jump target
  typedef logic [31:0] word_t;
  // Index into the result register file
  typedef logic [2:0]  reg_addr_t;
  // Wishbone word address
  typedef logic [3:0]  wb_addr_t;

  // Shift amounts come from operand B bits 4..0, upper bits ignored
  localparam int unsigned SHAMT_W = 5;

  // Result register file depth
  localparam int unsigned NUM_RES_REGS = 8;

  //////////////////////////////
  // Operations
  //////////////////////////////

  // Opcode field of the command word
  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    AND  = 5'd2,
    OR   = 5'd3,
    XOR  = 5'd4,
    SLL  = 5'd5,
    SRL  = 5'd6,
    SRA  = 5'd7,
    SLT  = 5'd8,
    SLTU = 5'd9,
    // Branch compares, A against B
    BEQ  = 5'd10,
    BNE  = 5'd11,
    BLT  = 5'd12,
    BGE  = 5'd13,
    BLTU = 5'd14,
    BGEU = 5'd15,
    // Multiplier group
    MUL  = 5'd16,
    MULH = 5'd17,
    MAC  = 5'd18
  } exu_op_e;

  // Multiplier operand signedness, code 3 behaves as UU
  typedef enum logic [1:0] {
    UU = 2'd0,
    SU = 2'd1,
    SS = 2'd2
  } mult_sign_e;

  //////////////////////////////
  // Host address map
  //////////////////////////////

  // Operand registers, write only
  localparam wb_addr_t ADR_OPA      = 4'd0;
  localparam wb_addr_t ADR_OPB      = 4'd1;
  localparam wb_addr_t ADR_OPC      = 4'd2;
  // Command register, a write launches the operation
  localparam wb_addr_t ADR_CMD      = 4'd3;
  // Results 8..15, read only
  localparam wb_addr_t ADR_RES_BASE = 4'd8;

  // Command word fields, other bits ignored
  localparam int unsigned CMD_OP_LSB   = 0;
  localparam int unsigned CMD_DEST_LSB = 5;
  localparam int unsigned CMD_WE_BIT   = 8;
  localparam int unsigned CMD_SIGN_LSB = 9;

endpackage

`default_nettype wire

// ==== rtl/exu_issue_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// One decoded operation on its way from decode to execute
interface exu_issue_if;
  import exu_pkg::*;

  // Handshake, transfer when both high on a rising edge
  logic       valid;
  logic       ready;

  // Control fields split out of the command word
  exu_op_e    op;
  mult_sign_e sign;
  reg_addr_t  dest;
  logic       we;

  // Operand snapshot taken with the command
  word_t      operand_a;
  word_t      operand_b;
  word_t      operand_c;

  modport decode_mp (
    output valid, op, sign, dest, we, operand_a, operand_b, operand_c,
    input  ready
  );

  modport execute_mp (
    input  valid, op, sign, dest, we, operand_a, operand_b, operand_c,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/exu_retire_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// One registered result on its way from execute to the result stage
interface exu_retire_if;
  import exu_pkg::*;

  // Same valid/ready rule as the issue side
  logic      valid;
  logic      ready;

  // Write target and payload
  reg_addr_t dest;
  logic      we;
  word_t     data;

  modport execute_mp (
    output valid, dest, we, data,
    input  ready
  );

  modport result_mp (
    input  valid, dest, we, data,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_alu
(
  input  exu_pkg::exu_op_e op_i,
  input  exu_pkg::word_t   operand_a_i,
  input  exu_pkg::word_t   operand_b_i,
  output exu_pkg::word_t   result_o,
  output logic             flag_o
);
  import exu_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt_s;
  logic               lt_u;

  // Only the low bits of B count as shift amount
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Shared comparators for SLT and the branch group
  assign eq   = operand_a_i == operand_b_i;
  assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u = operand_a_i < operand_b_i;

  // Branch decision
  always_comb
  begin
    case (op_i)
      BEQ:     flag_o = eq;
      BNE:     flag_o = ~eq;
      BLT:     flag_o = lt_s;
      BGE:     flag_o = ~lt_s;
      BLTU:    flag_o = lt_u;
      BGEU:    flag_o = ~lt_u;
      default: flag_o = 1'b0;
    endcase
  end

  always_comb
  begin
    case (op_i)
      ADD:  result_o = operand_a_i + operand_b_i;
      SUB:  result_o = operand_a_i - operand_b_i;
      AND:  result_o = operand_a_i & operand_b_i;
      OR:   result_o = operand_a_i | operand_b_i;
      XOR:  result_o = operand_a_i ^ operand_b_i;
      SLL:  result_o = operand_a_i << shamt;
      SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:  result_o = $signed(operand_a_i) >>> shamt;
      SLT:  result_o = {31'b0, lt_s};
      SLTU: result_o = {31'b0, lt_u};
      BEQ, BNE, BLT, BGE, BLTU, BGEU:
        result_o = {31'b0, flag_o};
      // Multiplier ops are picked up elsewhere
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exu_mult.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_mult
(
  input  exu_pkg::mult_sign_e sign_i,
  input  logic                mac_en_i,
  // Select upper product word
  input  logic                high_i,
  input  exu_pkg::word_t      op_a_i,
  input  exu_pkg::word_t      op_b_i,
  input  exu_pkg::word_t      acc_i,
  output exu_pkg::word_t      result_o
);
  import exu_pkg::*;

  logic               a_signed;
  logic               b_signed;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [63:0] prod;

  assign a_signed = (sign_i == SU) || (sign_i == SS);
  assign b_signed = sign_i == SS;

  // One extra bit turns every mode into a signed 33x33 multiply
  assign a_ext = {a_signed & op_a_i[31], op_a_i};
  assign b_ext = {b_signed & op_b_i[31], op_b_i};

  // 64 bits of the product are exact in all modes
  assign prod = a_ext * b_ext;

  always_comb
  begin
    if (high_i)
      result_o = prod[63:32];
    else if (mac_en_i)
      result_o = prod[31:0] + acc_i;
    else
      result_o = prod[31:0];
  end

endmodule

`default_nettype wire

// ==== rtl/exu_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_decode
(
  input  logic               clk,
  input  logic               rst_n,

  // Wishbone classic slave
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  exu_pkg::wb_addr_t  wb_adr_i,
  input  exu_pkg::word_t     wb_dat_i,
  output exu_pkg::word_t     wb_dat_o,
  output logic               wb_ack_o,

  // Result file read port
  output exu_pkg::reg_addr_t rd_addr_o,
  input  exu_pkg::word_t     rd_data_i,

  // Toward execute
  exu_issue_if.decode_mp     issue
);
  import exu_pkg::*;

  word_t   opa_q;
  word_t   opb_q;
  word_t   opc_q;
  logic    req;
  logic    wr_opa;
  logic    wr_opb;
  logic    wr_opc;
  logic    wr_cmd;
  logic    cmd_ok;
  logic    cmd_take;
  logic    ack_d;
  exu_op_e cmd_op;
  logic    cmd_branch;

  //////////////////////////////
  // Bus request decode
  //////////////////////////////

  // New request only while no ack is out, so each cycle gets one ack
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_opa = req & wb_we_i & (wb_adr_i == ADR_OPA);
  assign wr_opb = req & wb_we_i & (wb_adr_i == ADR_OPB);
  assign wr_opc = req & wb_we_i & (wb_adr_i == ADR_OPC);
  assign wr_cmd = req & wb_we_i & (wb_adr_i == ADR_CMD);

  // Decode register empty, or handed to execute on this edge
  assign cmd_ok   = ~issue.valid | issue.ready;
  assign cmd_take = wr_cmd & cmd_ok;

  // Command writes wait for room, everything else acks next cycle
  assign ack_d = req & (~wr_cmd | cmd_ok);

  // Command fields
  assign cmd_op     = exu_op_e'(wb_dat_i[CMD_OP_LSB +: $bits(exu_op_e)]);
  assign cmd_branch = cmd_op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

  // Low address bits pick the result register
  assign rd_addr_o = wb_adr_i[$bits(reg_addr_t)-1:0];

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack_o    <= 1'b0;
      issue.valid <= 1'b0;
    end
    else
    begin
      wb_ack_o <= ack_d;
      // Load wins over drain so back to back commands stream
      if (cmd_take)
        issue.valid <= 1'b1;
      else if (issue.ready)
        issue.valid <= 1'b0;
    end
  end

  //////////////////////////////
  // Operands and pipeline data
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (wr_opa)
      opa_q <= wb_dat_i;
    if (wr_opb)
      opb_q <= wb_dat_i;
    if (wr_opc)
      opc_q <= wb_dat_i;

    if (cmd_take)
    begin
      issue.op        <= cmd_op;
      issue.sign      <= mult_sign_e'(wb_dat_i[CMD_SIGN_LSB +: $bits(mult_sign_e)]);
      issue.dest      <= wb_dat_i[CMD_DEST_LSB +: $bits(reg_addr_t)];
      // Compares only steer the branch port, never the register file
      issue.we        <= wb_dat_i[CMD_WE_BIT] & ~cmd_branch;
      issue.operand_a <= opa_q;
      issue.operand_b <= opb_q;
      issue.operand_c <= opc_q;
    end

    // Read data goes out with the ack, operand and command space reads zero
    if (req & ~wb_we_i)
      wb_dat_o <= (wb_adr_i >= ADR_RES_BASE) ? rd_data_i : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/exu_execute.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_execute
(
  input  logic              clk,
  input  logic              rst_n,
  exu_issue_if.execute_mp   issue,
  exu_retire_if.execute_mp  retire,
  output logic              branch_valid_o,
  output logic              branch_taken_o,
  output exu_pkg::word_t    jump_target_o
);
  import exu_pkg::*;

  word_t     alu_result;
  logic      alu_flag;
  word_t     mult_result;
  logic      is_mult;
  logic      is_branch;
  logic      issue_hs;
  logic      retire_hs;

  // Execute/retire register
  logic      ex_valid_q;
  reg_addr_t ex_dest_q;
  logic      ex_we_q;
  word_t     ex_data_q;
  logic      ex_branch_q;
  logic      ex_taken_q;
  word_t     ex_target_q;

  assign is_mult   = issue.op inside {MUL, MULH, MAC};
  assign is_branch = issue.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

  exu_alu alu_i
  (
    .op_i        ( issue.op        ),
    .operand_a_i ( issue.operand_a ),
    .operand_b_i ( issue.operand_b ),
    .result_o    ( alu_result      ),
    .flag_o      ( alu_flag        )
  );

  // Operand C doubles as the accumulator
  exu_mult mult_i
  (
    .sign_i   ( issue.sign         ),
    .mac_en_i ( issue.op == MAC    ),
    .high_i   ( issue.op == MULH   ),
    .op_a_i   ( issue.operand_a    ),
    .op_b_i   ( issue.operand_b    ),
    .acc_i    ( issue.operand_c    ),
    .result_o ( mult_result        )
  );

  // Room when empty or when the result stage takes the entry this edge
  assign issue.ready = ~ex_valid_q | retire.ready;
  assign issue_hs    = issue.valid & issue.ready;
  assign retire_hs   = retire.valid & retire.ready;

  assign retire.valid = ex_valid_q;
  assign retire.dest  = ex_dest_q;
  assign retire.we    = ex_we_q;
  assign retire.data  = ex_data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid_q     <= 1'b0;
      branch_valid_o <= 1'b0;
      branch_taken_o <= 1'b0;
    end
    else
    begin
      if (issue_hs)
        ex_valid_q <= 1'b1;
      else if (retire_hs)
        ex_valid_q <= 1'b0;
      // Branch pulse lines up with the retire pulse of other ops
      branch_valid_o <= retire_hs & ex_branch_q;
      branch_taken_o <= retire_hs & ex_branch_q & ex_taken_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue_hs)
    begin
      ex_dest_q   <= issue.dest;
      ex_we_q     <= issue.we;
      ex_data_q   <= is_mult ? mult_result : alu_result;
      ex_branch_q <= is_branch;
      ex_taken_q  <= alu_flag;
      ex_target_q <= issue.operand_c;
    end
    if (retire_hs & ex_branch_q)
      jump_target_o <= ex_target_q;
  end

endmodule

`default_nettype wire

// ==== rtl/exu_result.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_result
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hold_i,
  exu_retire_if.result_mp    retire,
  input  exu_pkg::reg_addr_t rd_addr_i,
  output exu_pkg::word_t     rd_data_o,
  output logic               retire_valid_o,
  output exu_pkg::reg_addr_t retire_dest_o,
  output exu_pkg::word_t     retire_data_o
);
  import exu_pkg::*;

  word_t res_q [NUM_RES_REGS];
  logic  retire_hs;
  logic  wr_en;

  // Hold backs up the whole pipe from here
  assign retire.ready = ~hold_i;
  assign retire_hs    = retire.valid & retire.ready;
  assign wr_en        = retire_hs & retire.we;

  // Register file, cleared so unwritten entries read zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_RES_REGS; i++)
        res_q[i] <= '0;
      retire_valid_o <= 1'b0;
    end
    else
    begin
      if (wr_en)
        res_q[retire.dest] <= retire.data;
      retire_valid_o <= wr_en;
    end
  end

  // Pulse payload, held until the next write
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      retire_dest_o <= retire.dest;
      retire_data_o <= retire.data;
    end
  end

  // Host read, registered in decode
  assign rd_data_o = res_q[rd_addr_i];

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`default_nettype none
`timescale 1ns/1ps

// Command path: ack edge loads decode, next edge execute, next edge retires
module exu_top
(
  input  logic               clk,
  input  logic               rst_n,

  // Host bus
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  exu_pkg::wb_addr_t  wb_adr_i,
  input  exu_pkg::word_t     wb_dat_i,
  output exu_pkg::word_t     wb_dat_o,
  output logic               wb_ack_o,

  // Stall from downstream
  input  logic               hold_i,

  // Retired register writes
  output logic               retire_valid_o,
  output exu_pkg::reg_addr_t retire_dest_o,
  output exu_pkg::word_t     retire_data_o,

  // Branch outcomes
  output logic               branch_valid_o,
  output logic               branch_taken_o,
  output exu_pkg::word_t     jump_target_o
);
  import exu_pkg::*;

  reg_addr_t rd_addr;
  word_t     rd_data;

  exu_issue_if  issue_if ();
  exu_retire_if retire_if ();

  exu_decode decode_i
  (
    .clk       ( clk      ),
    .rst_n     ( rst_n    ),
    .wb_cyc_i  ( wb_cyc_i ),
    .wb_stb_i  ( wb_stb_i ),
    .wb_we_i   ( wb_we_i  ),
    .wb_adr_i  ( wb_adr_i ),
    .wb_dat_i  ( wb_dat_i ),
    .wb_dat_o  ( wb_dat_o ),
    .wb_ack_o  ( wb_ack_o ),
    .rd_addr_o ( rd_addr  ),
    .rd_data_i ( rd_data  ),
    .issue     ( issue_if )
  );

  exu_execute execute_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .issue          ( issue_if       ),
    .retire         ( retire_if      ),
    .branch_valid_o ( branch_valid_o ),
    .branch_taken_o ( branch_taken_o ),
    .jump_target_o  ( jump_target_o  )
  );

  exu_result result_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .hold_i         ( hold_i         ),
    .retire         ( retire_if      ),
    .rd_addr_i      ( rd_addr        ),
    .rd_data_o      ( rd_data        ),
    .retire_valid_o ( retire_valid_o ),
    .retire_dest_o  ( retire_dest_o  ),
    .retire_data_o  ( retire_data_o  )
  );

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ps

// Free running clock for the testbench
module tb_clkgen
#(
  parameter real PERIOD_NS = 40.0
)
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    // Half period high, half period low
    forever
    begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_checker
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wb_we_i,
  input  exu_pkg::wb_addr_t  wb_adr_i,
  input  exu_pkg::word_t     wb_dat_i,
  input  exu_pkg::word_t     wb_rdat_i,
  input  logic               wb_ack_i,
  input  logic               hold_i,
  input  logic               retire_valid_i,
  input  exu_pkg::reg_addr_t retire_dest_i,
  input  exu_pkg::word_t     retire_data_i,
  input  logic               branch_valid_i,
  input  logic               branch_taken_i,
  input  exu_pkg::word_t     jump_target_i
);
  import exu_pkg::*;

  // Ack edge loads decode, two more edges reach the retire pulse
  localparam int PIPE_EDGES = 2;

  // Expected entries, filled by the model in the testbench top
  reg_addr_t exp_dest_q [$];
  word_t     exp_data_q [$];
  logic      exp_taken_q [$];
  word_t     exp_target_q [$];
  word_t     exp_rd_q [$];
  // Edge numbers of accepted commands that owe a pulse
  int        accept_q [$];

  // Bus request as the DUT saw it on the last rising edge
  logic      bus_we_q;
  wb_addr_t  bus_adr_q;
  word_t     bus_dat_q;

  int        edge_cnt = 0;
  int        last_hold_edge = 0;
  int        checks = 0;
  int        errors = 0;
  int        lat_checks = 0;

  //////////////////////////////
  // Model side
  //////////////////////////////

  task automatic push_retire(input reg_addr_t dest, input word_t data);
    exp_dest_q.push_back(dest);
    exp_data_q.push_back(data);
  endtask

  task automatic push_branch(input logic taken, input word_t target);
    exp_taken_q.push_back(taken);
    exp_target_q.push_back(target);
  endtask

  task automatic push_read(input word_t data);
    exp_rd_q.push_back(data);
  endtask

  function automatic int pending();
    return exp_dest_q.size() + exp_taken_q.size() + exp_rd_q.size();
  endfunction

  // Drop leftovers so the next test starts aligned
  task automatic flush();
    exp_dest_q.delete();
    exp_data_q.delete();
    exp_taken_q.delete();
    exp_target_q.delete();
    exp_rd_q.delete();
    accept_q.delete();
  endtask

  //////////////////////////////
  // Comparing
  //////////////////////////////

  task automatic compare(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic fail(input string what);
    checks++;
    errors++;
    $display("error at edge %0d: %s", edge_cnt, what);
  endtask

  // Exact latency only when no stall could have landed in the window
  task automatic check_latency();
    int acc;
    int lat;
    if (accept_q.size() == 0)
    begin
      fail("pulse seen without an accepted command");
    end
    else
    begin
      acc = accept_q.pop_front();
      lat = edge_cnt - acc;
      if (last_hold_edge <= acc)
      begin
        lat_checks++;
        compare("latency", PIPE_EDGES, lat);
      end
      else if (lat < PIPE_EDGES)
        fail("pulse arrived earlier than the pipeline allows");
    end
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // Host drops or changes the request right after the ack edge
  always @(posedge clk)
  begin
    bus_we_q  <= wb_we_i;
    bus_adr_q <= wb_adr_i;
    bus_dat_q <= wb_dat_i;
  end

  // Falling edge, all DUT outputs and driven inputs are settled
  always @(negedge clk)
  begin
    edge_cnt = edge_cnt + 1;
    if (rst_n)
    begin
      // Command accepted on the edge that raised ack
      if (wb_ack_i && bus_we_q && bus_adr_q == ADR_CMD)
      begin
        if (bus_dat_q[CMD_WE_BIT] ||
            (bus_dat_q[CMD_OP_LSB +: 5] >= BEQ && bus_dat_q[CMD_OP_LSB +: 5] <= BGEU))
          accept_q.push_back(edge_cnt);
      end

      if (retire_valid_i)
      begin
        if (exp_dest_q.size() == 0)
          fail("retire pulse with no result expected");
        else
        begin
          compare("retire_dest_o", exp_dest_q.pop_front(), retire_dest_i);
          compare("retire_data_o", exp_data_q.pop_front(), retire_data_i);
          check_latency();
        end
      end

      if (branch_valid_i)
      begin
        if (exp_taken_q.size() == 0)
          fail("branch pulse with no branch expected");
        else
        begin
          compare("branch_taken_o", exp_taken_q.pop_front(), branch_taken_i);
          compare("jump_target_o", exp_target_q.pop_front(), jump_target_i);
          check_latency();
        end
      end

      // Host read data comes back with the ack
      if (wb_ack_i && !bus_we_q)
      begin
        if (exp_rd_q.size() == 0)
          fail("read ack with no read expected");
        else
          compare("wb_dat_o", exp_rd_q.pop_front(), wb_rdat_i);
      end

      // Value seen now is what the next rising edge uses
      if (hold_i)
        last_hold_edge = edge_cnt + 1;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_exu.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_exu;
  import exu_pkg::*;

  localparam int          RESET_CYCLES  = 10;
  localparam int          DRIVE_DLY     = 2;
  localparam int          WB_TIMEOUT    = 200;
  localparam int          DRAIN_TIMEOUT = 500;
  localparam logic [31:0] LFSR_SEED     = 32'd44;

  logic      clk;
  logic      rst_n;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  wb_addr_t  wb_adr_i;
  word_t     wb_dat_i;
  word_t     wb_dat_o;
  logic      wb_ack_o;
  logic      hold_i;
  logic      retire_valid_o;
  reg_addr_t retire_dest_o;
  word_t     retire_data_o;
  logic      branch_valid_o;
  logic      branch_taken_o;
  word_t     jump_target_o;

  logic [31:0] lfsr_q;
  // 0 no stall, 1 about a quarter of cycles, 2 about half
  int          hold_level;
  int          fails;
  int          pushed;
  int          base_checks;
  int          base_errors;
  word_t       model_regs [NUM_RES_REGS];

  tb_clkgen #(.PERIOD_NS(40.0)) clkgen_i
  (
    .clk_o ( clk )
  );

  exu_top exu_top_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .wb_cyc_i       ( wb_cyc_i       ),
    .wb_stb_i       ( wb_stb_i       ),
    .wb_we_i        ( wb_we_i        ),
    .wb_adr_i       ( wb_adr_i       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_dat_o       ( wb_dat_o       ),
    .wb_ack_o       ( wb_ack_o       ),
    .hold_i         ( hold_i         ),
    .retire_valid_o ( retire_valid_o ),
    .retire_dest_o  ( retire_dest_o  ),
    .retire_data_o  ( retire_data_o  ),
    .branch_valid_o ( branch_valid_o ),
    .branch_taken_o ( branch_taken_o ),
    .jump_target_o  ( jump_target_o  )
  );

  tb_checker chk_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .wb_we_i        ( wb_we_i        ),
    .wb_adr_i       ( wb_adr_i       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_rdat_i      ( wb_dat_o       ),
    .wb_ack_i       ( wb_ack_o       ),
    .hold_i         ( hold_i         ),
    .retire_valid_i ( retire_valid_o ),
    .retire_dest_i  ( retire_dest_o  ),
    .retire_data_i  ( retire_data_o  ),
    .branch_valid_i ( branch_valid_o ),
    .branch_taken_i ( branch_taken_o ),
    .jump_target_i  ( jump_target_o  )
  );

  //////////////////////////////
  // Random source
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit handed out
  task automatic get_rand(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t model_alu(input logic [4:0] op, input word_t a, input word_t b);
    logic [4:0] sh;
    logic       lt_s;
    sh = b[4:0];
    // Flipping the sign bits turns a signed compare into an unsigned one
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
      SLT:     return {31'b0, lt_s};
      SLTU:    return {31'b0, a < b};
      default: return '0;
    endcase
  endfunction

  function automatic logic model_flag(input logic [4:0] op, input word_t a, input word_t b);
    logic lt_s;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return lt_s;
      BGE:     return !lt_s;
      BLTU:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t model_mult(input logic [4:0] op, input logic [1:0] sign,
                                       input word_t a, input word_t b, input word_t c);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = {32'b0, a};
    xb = {32'b0, b};
    if (sign == SU || sign == SS)
      xa = {{32{a[31]}}, a};
    if (sign == SS)
      xb = {{32{b[31]}}, b};
    // Low 64 bits of the extended product are exact for every mode
    p = xa * xb;
    if (op == MULH)
      return p[63:32];
    else if (op == MAC)
      return p[31:0] + c;
    return p[31:0];
  endfunction

  //////////////////////////////
  // Bus driver
  //////////////////////////////

  task automatic next_cycle();
    word_t r;
    @(posedge clk);
    #DRIVE_DLY;
    case (hold_level)
      0: hold_i = 1'b0;
      1:
      begin
        get_rand(2, r);
        hold_i = (r[1:0] == 2'b00);
      end
      default:
      begin
        get_rand(1, r);
        hold_i = r[0];
      end
    endcase
  endtask

  // Classic cycle, request stays up until the ack is seen
  task automatic wb_xfer(input logic we, input wb_addr_t adr, input word_t dat,
                         output logic ok);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    next_cycle();
    n = 1;
    while (!wb_ack_o && n < WB_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    ok = wb_ack_o;
    if (!ok)
    begin
      $display("timeout: no ack for access to address %h after %0d cycles", adr, n);
      fails++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic run_op(input logic [4:0] op, input logic [1:0] sign, input reg_addr_t dest,
                        input logic we, input word_t a, input word_t b, input word_t c);
    word_t cmd;
    word_t res;
    logic  ok;
    cmd = '0;
    cmd[CMD_OP_LSB +: 5]   = op;
    cmd[CMD_DEST_LSB +: 3] = dest;
    cmd[CMD_WE_BIT]        = we;
    cmd[CMD_SIGN_LSB +: 2] = sign;
    wb_xfer(1'b1, ADR_OPA, a, ok);
    wb_xfer(1'b1, ADR_OPB, b, ok);
    wb_xfer(1'b1, ADR_OPC, c, ok);
    wb_xfer(1'b1, ADR_CMD, cmd, ok);
    if (ok)
    begin
      // Compares report on the branch port, operand C is the target
      if (op >= BEQ && op <= BGEU)
      begin
        chk_i.push_branch(model_flag(op, a, b), c);
        pushed++;
      end
      else if (we)
      begin
        if (op >= MUL)
          res = model_mult(op, sign, a, b, c);
        else
          res = model_alu(op, a, b);
        model_regs[dest] = res;
        chk_i.push_retire(dest, res);
        pushed++;
      end
    end
  endtask

  // sign_sel of 3 picks a random sign mode per command
  task automatic run_random(input int first_op, input int num_ops, input int count,
                            input int sign_sel);
    word_t a;
    word_t b;
    word_t c;
    word_t r;
    logic [4:0] op;
    logic [1:0] sign;
    for (int k = 0; k < count; k++)
    begin
      get_rand(32, a);
      get_rand(32, b);
      get_rand(32, c);
      get_rand(26, r);
      // Equal operands now and then so compares see both outcomes
      if (r[25:24] == 2'b00)
        b = a;
      op   = 5'(first_op + (r[23:16] % num_ops));
      sign = (sign_sel < 3) ? 2'(sign_sel) : 2'(r[15:8] % 3);
      // Most commands write back, a few leave the file alone
      run_op(op, sign, r[2:0], r[5:3] != 3'b000, a, b, c);
    end
  endtask

  //////////////////////////////
  // Test bookkeeping
  //////////////////////////////

  task automatic start_test(input int level);
    base_checks = chk_i.checks;
    base_errors = chk_i.errors + fails;
    hold_level  = level;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (chk_i.pending() != 0 && n < DRAIN_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    if (chk_i.pending() != 0)
    begin
      $display("timeout: %0d expected results never appeared", chk_i.pending());
      fails++;
      chk_i.flush();
    end
    // A few idle cycles so stray pulses show up in this test
    repeat (4) next_cycle();
  endtask

  task automatic finish_test(input string name);
    hold_level = 0;
    wait_drain();
    $display("test %-14s %0d checks, %0d errors", name, chk_i.checks - base_checks,
             chk_i.errors + fails - base_errors);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial
  begin
    int lat_base;
    int push_base;
    logic ok;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    hold_i     = 1'b0;
    rst_n      = 1'b0;
    lfsr_q     = LFSR_SEED;
    hold_level = 0;
    fails      = 0;
    pushed     = 0;
    for (int i = 0; i < NUM_RES_REGS; i++)
      model_regs[i] = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    next_cycle();

    start_test(1);
    run_random(ADD, 10, 200, 3);
    finish_test("alu");

    // Every sign mode against MUL, MULH and MAC
    start_test(1);
    for (int s = 0; s < 3; s++)
      run_random(MUL, 3, 30, s);
    finish_test("multiplier");

    start_test(1);
    run_random(BEQ, 6, 60, 3);
    finish_test("branch");

    start_test(2);
    run_random(ADD, 19, 120, 3);
    finish_test("backpressure");

    // No stall, so every pulse must take the exact pipeline latency
    start_test(0);
    lat_base  = chk_i.lat_checks;
    push_base = pushed;
    run_random(ADD, 16, 40, 3);
    finish_test("latency");
    if (chk_i.lat_checks - lat_base != pushed - push_base)
    begin
      $display("error: latency measured on %0d of %0d pulses",
               chk_i.lat_checks - lat_base, pushed - push_base);
      fails++;
    end

    start_test(0);
    for (int i = 0; i < NUM_RES_REGS; i++)
    begin
      chk_i.push_read(model_regs[i]);
      wb_xfer(1'b0, ADR_RES_BASE + wb_addr_t'(i), '0, ok);
    end
    finish_test("readback");

    $display("summary: %0d checks, %0d errors, %0d bus or drain failures",
             chk_i.checks, chk_i.errors, fails);
    if (chk_i.errors == 0 && fails == 0 && chk_i.checks > 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/exu_pkg.sv
rtl/exu_issue_if.sv
rtl/exu_retire_if.sv
rtl/exu_alu.sv
rtl/exu_mult.sv
rtl/exu_decode.sv
rtl/exu_execute.sv
rtl/exu_result.sv
rtl/exu_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_exu.sv
